/* design/dsi3_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// level codes 01, 10 and 11 carry chips C0, C1 and C2.
// code 00 is the idle line and decodes as the invalid chip CX.
// ~~~~~~~~~~~~~~~~~~~~
package dsi3_pkg;

	typedef enum logic [1:0] {
		C0 = 2'd0,
		C1 = 2'd1,
		C2 = 2'd2,
		CX = 2'd3
	} dsi3_chip;

	// chips[2] is the first chip received, chips[0] the last.
	typedef union packed {
		dsi3_chip [2:0] chips;
		logic     [5:0] raw;
	} dsi3_symbol;

	localparam int DSI3_MAX_NIBBLES = 8;

	localparam logic [1:0] DSI3_IDLE_LEVEL = 2'b00;

	// entry n holds the chip triple {first, second, third} for nibble n.
	localparam logic [15:0][5:0] DSI3_NIBBLE_TABLE = '{
		15: {C2, C1, C2}, 14: {C2, C1, C0}, 13: {C2, C0, C2}, 12: {C2, C0, C1},
		11: {C1, C2, C1}, 10: {C1, C2, C0}, 9: {C1, C1, C2}, 8: {C1, C1, C0},
		7: {C1, C0, C2}, 6: {C1, C0, C1}, 5: {C0, C2, C2}, 4: {C0, C2, C1},
		3: {C0, C2, C0}, 2: {C0, C1, C2}, 1: {C0, C1, C1}, 0: {C0, C1, C0}
	};

endpackage

/* design/dsi3_chip_if.sv */
// ~~~~~~~~~~~~~~~~~~~~
// chip stream from the detector, fanned out to two readers.
// chip, next_not_c0 and line_idle are valid only with chip_ready.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface dsi3_chip_if;
	import dsi3_pkg::*;

	dsi3_chip chip;
	logic     chip_ready;
	logic     next_not_c0;
	logic     line_idle;

	modport source (
		output chip, chip_ready, next_not_c0, line_idle
	);

	modport sink (
		input chip, chip_ready, next_not_c0, line_idle
	);

endinterface

/* design/dsi3_chip_detector.sv */
// ~~~~~~~~~~~~~~~~~~~~
// chip phase runs free from enable; the line must be chip aligned to it.
// each chip leaves one chip period late to carry a lookahead.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dsi3_chip_detector #(
	parameter int CHIP_CYCLES = 8,
	parameter int IDLE_CHIPS  = 2
) (
	input  logic             clk_rst,
	input  logic             i_rst_n,
	input  logic             i_enable,
	input  logic [1:0]       i_rx_level,
	dsi3_chip_if.source      chip_out
);
	import dsi3_pkg::*;

	localparam int PW  = (CHIP_CYCLES > 1) ? $clog2(CHIP_CYCLES) : 1;
	localparam int IW  = $clog2(IDLE_CHIPS + 1);
	localparam int MID = CHIP_CYCLES / 2;

	logic [PW-1:0] phase;
	logic [IW-1:0] idle_cnt, idle_cnt_nxt;
	dsi3_chip      sampled;
	dsi3_chip      held_chip;
	logic          have_held;

	always_comb begin
		case (i_rx_level)
			2'b01:   sampled = C0;
			2'b10:   sampled = C1;
			2'b11:   sampled = C2;
			default: sampled = CX;
		endcase
	end

	// idle samples saturate at IDLE_CHIPS.
	always_comb begin
		idle_cnt_nxt = '0;
		if (i_rx_level == DSI3_IDLE_LEVEL) begin
			idle_cnt_nxt = (idle_cnt == IW'(IDLE_CHIPS)) ? idle_cnt : idle_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk_rst or negedge i_rst_n) begin
		if (!i_rst_n) begin
			phase                <= '0;
			idle_cnt             <= '0;
			have_held            <= 1'b0;
			held_chip            <= CX;
			chip_out.chip        <= CX;
			chip_out.chip_ready  <= 1'b0;
			chip_out.next_not_c0 <= 1'b0;
			chip_out.line_idle   <= 1'b0;
		end else begin
			phase               <= (phase == PW'(CHIP_CYCLES - 1)) ? '0 : phase + 1'b1;
			chip_out.chip_ready <= 1'b0;
			if (!i_enable) begin
				idle_cnt  <= '0;
				have_held <= 1'b0;
			end else if (phase == PW'(MID)) begin
				held_chip <= sampled;
				have_held <= 1'b1;
				idle_cnt  <= idle_cnt_nxt;
				if (have_held) begin
					chip_out.chip        <= held_chip;
					chip_out.chip_ready  <= 1'b1;
					chip_out.next_not_c0 <= (sampled != C0);
					chip_out.line_idle   <= (idle_cnt_nxt == IW'(IDLE_CHIPS));
				end
			end
		end
	end

endmodule

/* design/dsi3_symbol_builder.sv */
// ~~~~~~~~~~~~~~~~~~~~
// groups three chips per symbol, first chip into the top slot.
// C0 C0 C0 with a C0 lookahead waits one chip before deciding.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dsi3_symbol_builder (
	input  logic                 clk_rst,
	input  logic                 i_rst_n,
	dsi3_chip_if.sink            chip_in,
	input  logic                 i_enable,
	input  logic                 i_stop_receiving,
	output logic                 o_received_0_as_first,
	output logic                 o_symbol_ready,
	output dsi3_pkg::dsi3_symbol o_symbol,
	output logic                 o_received_c0_after_packet
);
	import dsi3_pkg::*;

	typedef enum logic {SYM_IDLE, WAIT_NEXT_CHIP} sym_state_e;

	sym_state_e  state, state_nxt;
	logic [1:0]  chip_cnt, chip_cnt_nxt;
	dsi3_symbol  symbol_nxt;
	logic        symbol_ready, symbol_ready_nxt;
	logic        zero_first, zero_first_nxt;
	logic        c0_after, c0_after_nxt;
	logic        running;

	assign running = i_enable && !i_stop_receiving;

	assign o_symbol_ready             = symbol_ready;
	assign o_received_0_as_first      = zero_first;
	assign o_received_c0_after_packet = c0_after;

	always_ff @(posedge clk_rst or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state        <= SYM_IDLE;
			chip_cnt     <= 2'd2;
			symbol_ready <= 1'b0;
			zero_first   <= 1'b0;
			c0_after     <= 1'b0;
		end else begin
			state        <= state_nxt;
			chip_cnt     <= chip_cnt_nxt;
			symbol_ready <= symbol_ready_nxt;
			zero_first   <= zero_first_nxt;
			c0_after     <= c0_after_nxt;
		end
	end

	always_ff @(posedge clk_rst) begin
		o_symbol <= symbol_nxt;
	end

	// a C0 that lands on a symbol boundary is remembered until a non-C0 chip.
	always_comb begin
		c0_after_nxt = c0_after;
		if (chip_in.chip_ready) begin
			if (chip_in.chip != C0) begin
				c0_after_nxt = 1'b0;
			end else if (chip_cnt == 2'd2) begin
				c0_after_nxt = 1'b1;
			end
		end
		if (!running) begin
			c0_after_nxt = 1'b0;
		end
	end

	always_comb begin
		chip_cnt_nxt = chip_cnt;
		symbol_nxt   = o_symbol;
		if (!running) begin
			chip_cnt_nxt = 2'd2;
			symbol_nxt   = '{chips: '{CX, CX, CX}};
		end else if (chip_in.chip_ready) begin
			symbol_nxt.chips[chip_cnt] = chip_in.chip;
			chip_cnt_nxt = (chip_cnt == 2'd0) ? 2'd2 : chip_cnt - 2'd1;
		end
	end

	always_comb begin
		state_nxt        = state;
		symbol_ready_nxt = 1'b0;
		zero_first_nxt   = 1'b0;
		if (!running) begin
			state_nxt = SYM_IDLE;
		end else if (chip_in.chip_ready) begin
			case (state)
				SYM_IDLE: begin
					if (chip_cnt == 2'd0) begin
						if ((chip_in.chip == C0) && (o_symbol.chips[2] == C0) &&
							(o_symbol.chips[1] == C0) && !chip_in.next_not_c0) begin
							state_nxt = WAIT_NEXT_CHIP;
						end else begin
							symbol_ready_nxt = 1'b1;
						end
					end
				end
				WAIT_NEXT_CHIP: begin
					// the fourth C0 opens the next symbol.
					state_nxt = SYM_IDLE;
					if (chip_in.chip == C0) begin
						zero_first_nxt = 1'b1;
					end else begin
						symbol_ready_nxt = 1'b1;
					end
				end
				default: state_nxt = SYM_IDLE;
			endcase
		end
	end

endmodule

/* design/dsi3_packet_monitor.sv */
// ~~~~~~~~~~~~~~~~~~~~
// a packet ends on the idle line or after eight symbols of chips.
// the next non-idle chip reopens reception in the same cycle.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dsi3_packet_monitor #(
	parameter int IDLE_CHIPS = 2
) (
	input  logic        clk_rst,
	input  logic        i_rst_n,
	dsi3_chip_if.sink   chip_in,
	input  logic        i_enable,
	output logic        o_stop_receiving,
	output logic        o_packet_end
);
	import dsi3_pkg::*;

	localparam int MAX_CHIPS = 3 * DSI3_MAX_NIBBLES;

	logic [4:0] chip_cnt;
	logic       ended;
	logic       resume;

	assign resume           = ended && chip_in.chip_ready && (chip_in.chip != CX);
	assign o_stop_receiving = ended && !resume;

	always_ff @(posedge clk_rst or negedge i_rst_n) begin
		if (!i_rst_n) begin
			chip_cnt     <= '0;
			ended        <= 1'b1;
			o_packet_end <= 1'b0;
		end else begin
			o_packet_end <= 1'b0;
			if (!i_enable) begin
				chip_cnt <= '0;
				ended    <= 1'b1;
			end else if (resume) begin
				chip_cnt <= 5'd1;
				ended    <= 1'b0;
			end else if (!ended && chip_in.chip_ready) begin
				if (chip_in.line_idle || (chip_cnt == 5'(MAX_CHIPS - 1))) begin
					chip_cnt     <= '0;
					ended        <= 1'b1;
					o_packet_end <= 1'b1;
				end else begin
					chip_cnt <= chip_cnt + 5'd1;
				end
			end
		end
	end

endmodule

/* design/dsi3_data_assembler.sv */
// ~~~~~~~~~~~~~~~~~~~~
// nibbles shift in from the right; only the first eight are counted.
// error and leading-zero flags hold for one packet.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dsi3_data_assembler (
	input  logic                 clk_rst,
	input  logic                 i_rst_n,
	input  logic                 i_enable,
	input  logic                 i_symbol_ready,
	input  dsi3_pkg::dsi3_symbol i_symbol,
	input  logic                 i_received_0_as_first,
	input  logic                 i_received_c0_after_packet,
	input  logic                 i_packet_end,
	output logic [3:0]           o_nibble,
	output logic                 o_nibble_valid,
	output logic [31:0]          o_packet_data,
	output logic [3:0]           o_packet_nibbles,
	output logic                 o_packet_valid,
	output logic                 o_symbol_error,
	output logic                 o_leading_zero
);
	import dsi3_pkg::*;

	logic [31:0] word, word_nxt;
	logic [3:0]  nib_cnt, nib_cnt_nxt;
	logic [3:0]  decoded, add_val;
	logic        found, add;
	logic        err, err_nxt, lz, lz_nxt;

	always_comb begin
		found   = 1'b0;
		decoded = 4'd0;
		for (int i = 0; i < 16; i++) begin
			if (i_symbol.raw == DSI3_NIBBLE_TABLE[i]) begin
				found   = 1'b1;
				decoded = 4'(i);
			end
		end
	end

	// a leading zero enters the word as nibble 0.
	assign add         = i_symbol_ready || i_received_0_as_first;
	assign add_val     = i_symbol_ready ? decoded : 4'd0;
	assign word_nxt    = add ? {word[27:0], add_val} : word;
	assign nib_cnt_nxt = (add && (nib_cnt != 4'(DSI3_MAX_NIBBLES))) ? nib_cnt + 4'd1 : nib_cnt;
	assign err_nxt     = err | (i_symbol_ready & ~found);
	assign lz_nxt      = lz | (i_received_0_as_first & i_received_c0_after_packet);

	always_ff @(posedge clk_rst or negedge i_rst_n) begin
		if (!i_rst_n) begin
			nib_cnt          <= '0;
			err              <= 1'b0;
			lz               <= 1'b0;
			o_nibble_valid   <= 1'b0;
			o_packet_valid   <= 1'b0;
			o_packet_nibbles <= '0;
			o_symbol_error   <= 1'b0;
			o_leading_zero   <= 1'b0;
		end else if (!i_enable) begin
			nib_cnt        <= '0;
			err            <= 1'b0;
			lz             <= 1'b0;
			o_nibble_valid <= 1'b0;
			o_packet_valid <= 1'b0;
		end else begin
			o_nibble_valid <= add;
			o_packet_valid <= i_packet_end;
			if (i_packet_end) begin
				o_packet_nibbles <= nib_cnt_nxt;
				o_symbol_error   <= err_nxt;
				o_leading_zero   <= lz_nxt;
				nib_cnt          <= '0;
				err              <= 1'b0;
				lz               <= 1'b0;
			end else begin
				nib_cnt <= nib_cnt_nxt;
				err     <= err_nxt;
				lz      <= lz_nxt;
			end
		end
	end

	always_ff @(posedge clk_rst) begin
		o_nibble <= add_val;
		word     <= (i_packet_end || !i_enable) ? 32'd0 : word_nxt;
		if (i_packet_end && i_enable) begin
			o_packet_data <= word_nxt;
		end
	end

endmodule

/* design/dsi3_receiver.sv */
// ~~~~~~~~~~~~~~~~~~~~
// DSI3 receive path from level codes to packet words.
// dropping i_enable discards the packet in flight.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dsi3_receiver #(
	parameter int CHIP_CYCLES = 8,
	parameter int IDLE_CHIPS  = 2
) (
	input  logic        clk_rst,
	input  logic        i_rst_n,
	input  logic        i_enable,
	input  logic [1:0]  i_rx_level,
	output logic [3:0]  o_nibble,
	output logic        o_nibble_valid,
	output logic [31:0] o_packet_data,
	output logic [3:0]  o_packet_nibbles,
	output logic        o_packet_valid,
	output logic        o_symbol_error,
	output logic        o_leading_zero
);
	import dsi3_pkg::*;

	dsi3_chip_if chip_bus ();

	dsi3_symbol symbol;
	logic       symbol_ready, zero_first, c0_after, stop_receiving, packet_end;

	dsi3_chip_detector #(.CHIP_CYCLES(CHIP_CYCLES), .IDLE_CHIPS(IDLE_CHIPS)) u_detector (
		.clk_rst(clk_rst), .i_rst_n(i_rst_n), .i_enable(i_enable),
		.i_rx_level(i_rx_level), .chip_out(chip_bus.source)
	);

	dsi3_symbol_builder u_builder (
		.clk_rst(clk_rst), .i_rst_n(i_rst_n), .chip_in(chip_bus.sink),
		.i_enable(i_enable), .i_stop_receiving(stop_receiving),
		.o_received_0_as_first(zero_first), .o_symbol_ready(symbol_ready),
		.o_symbol(symbol), .o_received_c0_after_packet(c0_after)
	);

	dsi3_packet_monitor #(.IDLE_CHIPS(IDLE_CHIPS)) u_monitor (
		.clk_rst(clk_rst), .i_rst_n(i_rst_n), .chip_in(chip_bus.sink),
		.i_enable(i_enable), .o_stop_receiving(stop_receiving), .o_packet_end(packet_end)
	);

	dsi3_data_assembler u_assembler (
		.clk_rst(clk_rst), .i_rst_n(i_rst_n), .i_enable(i_enable),
		.i_symbol_ready(symbol_ready), .i_symbol(symbol),
		.i_received_0_as_first(zero_first), .i_received_c0_after_packet(c0_after),
		.i_packet_end(packet_end), .o_nibble(o_nibble), .o_nibble_valid(o_nibble_valid),
		.o_packet_data(o_packet_data), .o_packet_nibbles(o_packet_nibbles),
		.o_packet_valid(o_packet_valid), .o_symbol_error(o_symbol_error),
		.o_leading_zero(o_leading_zero)
	);

endmodule

/* tb/dsi3_receiver_chk.sv */
// ~~~~~~~~~~~~~~~~~~~~
// strobe checks on the symbol builder outputs and the packet strobe.
// bound into the receiver, where the builder outputs are visible as nets.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dsi3_receiver_chk (
	input logic clk_rst,
	input logic i_rst_n,
	input logic i_enable,
	input logic i_symbol_ready,
	input logic i_zero_first,
	input logic i_packet_valid
);

	// a symbol and a leading zero are never reported in the same cycle.
	strobes_exclusive: assert property (@(posedge clk_rst) disable iff (!i_rst_n)
		!(i_symbol_ready && i_zero_first))
		else $error("symbol_ready and received_0_as_first high together");

	// a cycle with enable low leaves both strobes low after the next edge.
	strobes_need_enable: assert property (@(posedge clk_rst) disable iff (!i_rst_n)
		!i_enable |=> !(i_symbol_ready || i_zero_first))
		else $error("builder strobe rose while i_enable is low");

	packet_valid_single: assert property (@(posedge clk_rst) disable iff (!i_rst_n)
		i_packet_valid |=> !i_packet_valid)
		else $error("o_packet_valid held longer than one cycle");

endmodule

bind dsi3_receiver dsi3_receiver_chk u_chk (
	.clk_rst(clk_rst),
	.i_rst_n(i_rst_n),
	.i_enable(i_enable),
	.i_symbol_ready(symbol_ready),
	.i_zero_first(zero_first),
	.i_packet_valid(o_packet_valid)
);

/* tb/tb_dsi3_receiver.sv */
// ~~~~~~~~~~~~~~~~~~~~
// chip-level stimulus for the DSI3 receiver with default parameters.
// each chip is held for CHIP_CYCLES clocks; packets are split by idle.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_dsi3_receiver;
	import dsi3_pkg::*;

	localparam int CHIP_CYCLES    = 8;
	localparam int NUM_RANDOM     = 10;
	localparam int NUM_PACKETS    = NUM_RANDOM + 7;
	localparam int WAIT_CHIPS     = 6;
	localparam int SLOT_CHIPS     = 3 * DSI3_MAX_NIBBLES + 12;
	localparam int TIMEOUT_CYCLES = NUM_PACKETS * SLOT_CHIPS * CHIP_CYCLES + 200;

	// chip triple {first, second, third} for each nibble value.
	localparam logic [5:0] SYM_TABLE [16] = '{
		{C0, C1, C0}, {C0, C1, C1}, {C0, C1, C2}, {C0, C2, C0},
		{C0, C2, C1}, {C0, C2, C2}, {C1, C0, C1}, {C1, C0, C2},
		{C1, C1, C0}, {C1, C1, C2}, {C1, C2, C0}, {C1, C2, C1},
		{C2, C0, C1}, {C2, C0, C2}, {C2, C1, C0}, {C2, C1, C2}
	};
	localparam logic [5:0] BAD_SYMBOL = {C2, C2, C2};

	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  nibbles;
		logic        err;
		logic        lz;
		logic        check_data;
	} expect_t;

	logic        clk_rst;
	logic        i_rst_n;
	logic        i_enable;
	logic [1:0]  i_rx_level;
	logic [3:0]  o_nibble;
	logic        o_nibble_valid;
	logic [31:0] o_packet_data;
	logic [3:0]  o_packet_nibbles;
	logic        o_packet_valid;
	logic        o_symbol_error;
	logic        o_leading_zero;

	expect_t     exp_q[$];
	logic [5:0]  tx_syms[$];
	logic [31:0] seen_word = 32'd0;
	int          seen_cnt = 0;
	int          seed;
	int          cycles = 0;
	int          mismatch_cnt = 0;
	int          missing_cnt = 0;
	int          unexpected_cnt = 0;
	int          packets_seen = 0;

	dsi3_receiver UUT (
		.clk_rst(clk_rst), .i_rst_n(i_rst_n), .i_enable(i_enable),
		.i_rx_level(i_rx_level), .o_nibble(o_nibble), .o_nibble_valid(o_nibble_valid),
		.o_packet_data(o_packet_data), .o_packet_nibbles(o_packet_nibbles),
		.o_packet_valid(o_packet_valid), .o_symbol_error(o_symbol_error),
		.o_leading_zero(o_leading_zero)
	);

	initial clk_rst = 1'b0;
	always #4 clk_rst = ~clk_rst;

	// top bit flags a triple that is not a valid symbol.
	function automatic logic [4:0] ref_decode(input logic [5:0] triple);
		ref_decode = {1'b1, 4'd0};
		for (int n = 0; n < 16; n++) begin
			if (SYM_TABLE[n] == triple) begin
				ref_decode = {1'b0, 4'(n)};
			end
		end
	endfunction

	function automatic logic [1:0] level_of(input dsi3_chip c);
		case (c)
			C0:      level_of = 2'b01;
			C1:      level_of = 2'b10;
			C2:      level_of = 2'b11;
			default: level_of = DSI3_IDLE_LEVEL;
		endcase
	endfunction

	function automatic logic [3:0] random_nibble();
		return 4'($unsigned($random(seed)) % 16);
	endfunction

	// called 1 ns after a rising edge and returns at the same offset.
	task automatic hold_level(input logic [1:0] level, input int chips);
		i_rx_level = level;
		repeat (chips * CHIP_CYCLES) @(posedge clk_rst);
		#1;
	endtask

	task automatic send_chip(input dsi3_chip c);
		hold_level(level_of(c), 1);
	endtask

	task automatic send_symbol(input logic [5:0] triple);
		send_chip(dsi3_chip'(triple[5:4]));
		send_chip(dsi3_chip'(triple[3:2]));
		send_chip(dsi3_chip'(triple[1:0]));
	endtask

	task automatic fill_random(input int count);
		tx_syms.delete();
		repeat (count) tx_syms.push_back(SYM_TABLE[random_nibble()]);
	endtask

	// a leading zero enters the word as a zero nibble ahead of the symbols.
	task automatic queue_expected(input logic lead_zero);
		expect_t    e;
		logic [4:0] dec;
		int         count;
		e.data = 32'd0;
		e.err  = 1'b0;
		e.lz   = lead_zero;
		count  = lead_zero ? 1 : 0;
		foreach (tx_syms[i]) begin
			dec    = ref_decode(tx_syms[i]);
			e.err  = e.err | dec[4];
			e.data = {e.data[27:0], dec[3:0]};
			count++;
		end
		e.nibbles    = 4'(count);
		e.check_data = !e.err;
		exp_q.push_back(e);
	endtask

	task automatic send_symbols(input logic lead_zero);
		if (lead_zero) begin
			repeat (3) send_chip(C0);
		end
		foreach (tx_syms[i]) begin
			send_symbol(tx_syms[i]);
		end
	endtask

	task automatic finish_packet();
		int waited;
		hold_level(DSI3_IDLE_LEVEL, 2);
		waited = 0;
		while (exp_q.size() != 0 && waited < WAIT_CHIPS * CHIP_CYCLES) begin
			@(posedge clk_rst);
			#1;
			waited++;
		end
		if (exp_q.size() != 0) begin
			$display("packet %0d never arrived at o_packet_valid", packets_seen + 1);
			missing_cnt += exp_q.size();
			exp_q.delete();
		end
		hold_level(DSI3_IDLE_LEVEL, 1);
	endtask

	// nibble strobes are gathered into a word and checked with their packet.
	always @(negedge clk_rst) begin : compare_packets
		expect_t e;
		if (i_rst_n && o_nibble_valid) begin
			seen_word = {seen_word[27:0], o_nibble};
			seen_cnt++;
		end
		if (i_rst_n && o_packet_valid) begin
			packets_seen++;
			if (exp_q.size() == 0) begin
				$display("o_packet_valid rose while no packet was expected");
				unexpected_cnt++;
			end else begin
				e = exp_q.pop_front();
				if (e.check_data && o_packet_data != e.data) begin
					$display("Mismatch o_packet_data: got %h, expected %h", o_packet_data, e.data);
					mismatch_cnt++;
				end
				if (e.check_data && seen_word != e.data) begin
					$display("Mismatch o_nibble: got %h, expected %h", seen_word, e.data);
					mismatch_cnt++;
				end
				if (seen_cnt != e.nibbles) begin
					$display("Mismatch o_nibble_valid count: got %h, expected %h",
						seen_cnt, e.nibbles);
					mismatch_cnt++;
				end
				if (o_packet_nibbles != e.nibbles) begin
					$display("Mismatch o_packet_nibbles: got %h, expected %h",
						o_packet_nibbles, e.nibbles);
					mismatch_cnt++;
				end
				if (o_symbol_error != e.err) begin
					$display("Mismatch o_symbol_error: got %h, expected %h", o_symbol_error, e.err);
					mismatch_cnt++;
				end
				if (o_leading_zero != e.lz) begin
					$display("Mismatch o_leading_zero: got %h, expected %h", o_leading_zero, e.lz);
					mismatch_cnt++;
				end
			end
			seen_word = 32'd0;
			seen_cnt  = 0;
		end
		if (!i_enable) begin
			seen_word = 32'd0;
			seen_cnt  = 0;
		end
	end

	always @(posedge clk_rst) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("run stopped by the timeout after %0d cycles", cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	initial begin : stimulus
		logic [3:0] nib;
		seed       = 32'h259078d2;
		i_rst_n    = 1'b0;
		i_enable   = 1'b0;
		i_rx_level = DSI3_IDLE_LEVEL;
		repeat (3) @(posedge clk_rst);
		#1;
		i_rst_n = 1'b1;
		if ({o_packet_valid, o_nibble_valid, o_symbol_error, o_leading_zero} != 4'h0) begin
			$display("Mismatch reset outputs: got %h, expected 0",
				{o_packet_valid, o_nibble_valid, o_symbol_error, o_leading_zero});
			mismatch_cnt++;
		end
		i_enable = 1'b1;
		hold_level(DSI3_IDLE_LEVEL, 3);

		repeat (NUM_RANDOM) begin
			fill_random(1 + ($unsigned($random(seed)) % DSI3_MAX_NIBBLES));
			queue_expected(1'b0);
			send_symbols(1'b0);
			finish_packet();
		end

		// ~~~~~~~~~~~~~~~~~~~~
		// leading zero, then a bad symbol followed by a clean packet.
		nib = random_nibble();
		tx_syms.delete();
		tx_syms.push_back(SYM_TABLE[nib % 4'd6]);
		tx_syms.push_back(SYM_TABLE[random_nibble()]);
		tx_syms.push_back(SYM_TABLE[random_nibble()]);
		queue_expected(1'b1);
		send_symbols(1'b1);
		finish_packet();

		fill_random(2);
		tx_syms.insert(1, BAD_SYMBOL);
		queue_expected(1'b0);
		send_symbols(1'b0);
		finish_packet();
		fill_random(3);
		queue_expected(1'b0);
		send_symbols(1'b0);
		finish_packet();

		// ~~~~~~~~~~~~~~~~~~~~
		// a full packet ends by count and the next one follows with no gap.
		fill_random(DSI3_MAX_NIBBLES);
		queue_expected(1'b0);
		send_symbols(1'b0);
		fill_random(3);
		queue_expected(1'b0);
		send_symbols(1'b0);
		finish_packet();

		// ~~~~~~~~~~~~~~~~~~~~
		// enable drops in the third symbol; that packet must be discarded.
		fill_random(3);
		send_symbol(tx_syms[0]);
		send_symbol(tx_syms[1]);
		send_chip(dsi3_chip'(tx_syms[2][5:4]));
		i_enable = 1'b0;
		hold_level(DSI3_IDLE_LEVEL, 4);
		i_enable = 1'b1;
		hold_level(DSI3_IDLE_LEVEL, 3);
		fill_random(4);
		queue_expected(1'b0);
		send_symbols(1'b0);
		finish_packet();

		$display("errors: %0d mismatch, %0d missing, %0d unexpected, %0d packets seen",
			mismatch_cnt, missing_cnt, unexpected_cnt, packets_seen);
		if (mismatch_cnt + missing_cnt + unexpected_cnt == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

/* src.f */
design/dsi3_pkg.sv
design/dsi3_chip_if.sv
design/dsi3_chip_detector.sv
design/dsi3_symbol_builder.sv
design/dsi3_packet_monitor.sv
design/dsi3_data_assembler.sv
design/dsi3_receiver.sv
tb/dsi3_receiver_chk.sv
tb/tb_dsi3_receiver.sv

/* run.sh */
#!/bin/sh
# Build and run the DSI3 receiver testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_dsi3_receiver \
	-Mdir obj_dir -o sim_tb_dsi3_receiver

./obj_dir/sim_tb_dsi3_receiver > sim.log 2>&1 || true
cat sim.log

grep -q "TB PASSED" sim.log
